/* logic/icache_pkg.sv */
package icache_pkg;

  ////////////////////////////////
  // geometry
  ////////////////////////////////

  // physical byte address
  localparam int unsigned addr_width     = 32;
  localparam int unsigned line_bytes     = 16;
  localparam int unsigned num_sets       = 64;
  // address split into tag | index | offset
  localparam int unsigned offset_width   = $clog2(line_bytes);
  localparam int unsigned index_width    = $clog2(num_sets);
  localparam int unsigned tag_width      = addr_width - index_width - offset_width;
  // 32-bit words per line select
  localparam int unsigned word_off_width = offset_width - 2;

  ////////////////////////////////
  // vector types
  ////////////////////////////////

  typedef logic [addr_width-1:0]     addr_t;
  typedef logic [tag_width-1:0]      tag_t;
  typedef logic [index_width-1:0]    set_idx_t;
  typedef logic [word_off_width-1:0] word_off_t;
  typedef logic [31:0]               word_t;
  typedef logic [8*line_bytes-1:0]   line_t;

  // fetch channel
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    word_t data;
  } fetch_rsp_t;

  // refill channel, line_addr has the offset bits cleared
  typedef struct packed {
    addr_t line_addr;
  } refill_req_t;

  typedef struct packed {
    line_t data;
  } refill_rsp_t;

endpackage

/* logic/icache_lookup.sv */
`timescale 1ns/1ns

module icache_lookup (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::fetch_req_t fetch_req_i,
  input  logic                   capture_i,
  output icache_pkg::set_idx_t   index_o,
  output icache_pkg::tag_t       tag_o,
  output icache_pkg::word_off_t  word_off_o,
  output icache_pkg::addr_t      line_addr_o
);

  // address of the request under compare or refill
  icache_pkg::addr_t    addr_q;
  // set index of the incoming request
  icache_pkg::set_idx_t index_in;
  icache_pkg::set_idx_t index_q;

  assign index_in = fetch_req_i.addr[icache_pkg::offset_width +: icache_pkg::index_width];
  assign index_q  = addr_q[icache_pkg::offset_width +: icache_pkg::index_width];

  // take the address on acceptance, hold it otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (capture_i) begin
      addr_q <= fetch_req_i.addr;
    end
  end

  // arrays read with the new index in the acceptance cycle
  assign index_o = capture_i ? index_in : index_q;

  // held fields for compare and refill
  assign tag_o      = addr_q[icache_pkg::addr_width-1 -: icache_pkg::tag_width];
  assign word_off_o = addr_q[icache_pkg::offset_width-1 -: icache_pkg::word_off_width];

  // refill goes out line aligned
  assign line_addr_o = {tag_o, index_q, {icache_pkg::offset_width{1'b0}}};

endmodule

/* logic/icache_arrays.sv */
`timescale 1ns/1ns

module icache_arrays #(
  parameter int unsigned num_ways = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                rd_en_i,
  input  logic                                wr_en_i,
  input  logic                                flush_en_i,
  input  icache_pkg::set_idx_t                flush_idx_i,
  input  icache_pkg::set_idx_t                index_i,
  input  icache_pkg::tag_t                    tag_i,
  input  logic [num_ways-1:0]                 wr_way_i,
  input  icache_pkg::line_t                   line_i,
  output icache_pkg::tag_t  [num_ways-1:0]    tags_o,
  output logic              [num_ways-1:0]    valids_o,
  output icache_pkg::line_t [num_ways-1:0]    lines_o
);

  ////////////////////////////////
  // storage
  ////////////////////////////////

  icache_pkg::tag_t  tag_mem  [num_ways][icache_pkg::num_sets];
  icache_pkg::line_t data_mem [num_ways][icache_pkg::num_sets];
  // valid bits, one vector of ways per set
  logic [num_ways-1:0] valid_mem [icache_pkg::num_sets];

  // tag and line write into the victim way
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < num_ways; w++) begin
      if (wr_en_i && wr_way_i[w]) begin
        tag_mem[w][index_i]  <= tag_i;
        data_mem[w][index_i] <= line_i;
      end
    end
  end

  // flush walk clears one set per cycle
  // a write only ever sets the bit of its own way
  always_ff @(posedge clk_i) begin
    if (flush_en_i) begin
      valid_mem[flush_idx_i] <= '0;
    end else if (wr_en_i) begin
      valid_mem[index_i] <= valid_mem[index_i] | wr_way_i;
    end
  end

  ////////////////////////////////
  // read port, one cycle latency
  ////////////////////////////////

  // outputs hold between reads so the miss path still sees the set
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      for (int w = 0; w < num_ways; w++) begin
        tags_o[w]  <= tag_mem[w][index_i];
        lines_o[w] <= data_mem[w][index_i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valids_o <= '0;
    end else if (rd_en_i) begin
      valids_o <= valid_mem[index_i];
    end
  end

endmodule

/* logic/icache_replace.sv */
`timescale 1ns/1ns

module icache_replace #(
  parameter int unsigned num_ways = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [num_ways-1:0] valids_i,
  input  logic                latch_i,
  input  logic                advance_i,
  output logic [num_ways-1:0] victim_o
);

  localparam int unsigned way_bits = $clog2(num_ways);

  logic [7:0]          lfsr_q;
  logic                lfsr_fb;
  // lowest invalid way, one-hot
  logic [num_ways-1:0] inv_oh;
  logic                found;
  // pseudo-random way, one-hot
  logic [num_ways-1:0] rnd_oh;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_comb begin
    inv_oh = '0;
    found  = 1'b0;
    for (int i = 0; i < num_ways; i++) begin
      if (!valids_i[i] && !found) begin
        inv_oh[i] = 1'b1;
        found     = 1'b1;
      end
    end
    rnd_oh = '0;
    rnd_oh[lfsr_q[way_bits-1:0]] = 1'b1;
  end

  // lfsr steps only on a write into a full set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q   <= 8'hff;
      victim_o <= '0;
    end else begin
      if (advance_i) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
      // invalid way first, random only when the set is full
      if (latch_i) begin
        victim_o <= found ? inv_oh : rnd_oh;
      end
    end
  end

endmodule

/* logic/icache_hit_check.sv */
`timescale 1ns/1ns

module icache_hit_check #(
  parameter int unsigned num_ways = 4
) (
  input  icache_pkg::tag_t  [num_ways-1:0] tags_i,
  input  logic              [num_ways-1:0] valids_i,
  input  icache_pkg::line_t [num_ways-1:0] lines_i,
  input  icache_pkg::tag_t                 tag_i,
  input  icache_pkg::word_off_t            word_off_i,
  output logic                             hit_o,
  output icache_pkg::word_t                word_o
);

  localparam int unsigned way_bits  = $clog2(num_ways);
  localparam int unsigned word_bits = $bits(icache_pkg::word_t);

  // per-way match
  logic [num_ways-1:0] hit_vec;
  logic [way_bits-1:0] hit_sel;

  always_comb begin
    for (int i = 0; i < num_ways; i++) begin
      hit_vec[i] = valids_i[i] && (tags_i[i] == tag_i);
    end
  end

  // lowest matching way wins
  always_comb begin
    hit_sel = '0;
    for (int i = num_ways - 1; i >= 0; i--) begin
      if (hit_vec[i]) begin
        hit_sel = way_bits'(i);
      end
    end
  end

  assign hit_o  = |hit_vec;
  // addressed word of the selected line
  assign word_o = lines_i[hit_sel][word_off_i * word_bits +: word_bits];

endmodule

/* logic/icache_ctrl.sv */
`timescale 1ns/1ns

module icache_ctrl #(
  parameter int unsigned num_ways = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    fetch_req_valid_i,
  output logic                    fetch_req_ready_o,
  output logic                    capture_o,
  input  logic                    hit_i,
  input  icache_pkg::word_t       hit_word_i,
  input  logic                    refill_req_ready_i,
  output logic                    refill_req_valid_o,
  input  logic                    refill_rsp_valid_i,
  input  icache_pkg::refill_rsp_t refill_rsp_i,
  input  icache_pkg::word_off_t   word_off_i,
  output logic                    fetch_rsp_valid_o,
  output icache_pkg::fetch_rsp_t  fetch_rsp_o,
  output logic                    rd_en_o,
  output logic                    wr_en_o,
  output logic                    flush_en_o,
  output icache_pkg::set_idx_t    flush_idx_o,
  output logic                    latch_o,
  output logic                    advance_o,
  input  logic [num_ways-1:0]     full_i,
  output logic                    miss_o
);

  localparam int unsigned word_bits = $bits(icache_pkg::word_t);

  typedef enum logic [1:0] {
    ctrl_flush,
    ctrl_idle,
    ctrl_compare,
    ctrl_miss
  } ctrl_state_e;

  ctrl_state_e          state_d, state_q;
  icache_pkg::set_idx_t flush_cnt_d, flush_cnt_q;
  // remembered flush request
  logic                 flush_pend_d, flush_pend_q;
  logic                 flush_last;

  assign flush_idx_o = flush_cnt_q;
  assign flush_last  = flush_cnt_q == icache_pkg::set_idx_t'(icache_pkg::num_sets - 1);

  ////////////////////////////////
  // next state and outputs
  ////////////////////////////////

  always_comb begin
    state_d            = state_q;
    flush_cnt_d        = flush_cnt_q;
    flush_pend_d       = flush_pend_q | flush_i;
    fetch_req_ready_o  = 1'b0;
    capture_o          = 1'b0;
    rd_en_o            = 1'b0;
    wr_en_o            = 1'b0;
    flush_en_o         = 1'b0;
    latch_o            = 1'b0;
    advance_o          = 1'b0;
    refill_req_valid_o = 1'b0;
    fetch_rsp_valid_o  = 1'b0;
    fetch_rsp_o.data   = hit_word_i;
    miss_o             = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      ctrl_flush: begin
        flush_en_o  = 1'b1;
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_last) begin
          flush_cnt_d  = '0;
          flush_pend_d = 1'b0;
          state_d      = ctrl_idle;
        end
      end
      // pending flush goes first, else accept
      ctrl_idle: begin
        if (flush_pend_d) begin
          state_d = ctrl_flush;
        end else begin
          fetch_req_ready_o = 1'b1;
          if (fetch_req_valid_i) begin
            capture_o = 1'b1;
            rd_en_o   = 1'b1;
            state_d   = ctrl_compare;
          end
        end
      end
      // tags are at the array outputs now
      ctrl_compare: begin
        // victim taken from this set's valid bits
        latch_o = 1'b1;
        if (hit_i) begin
          fetch_rsp_valid_o = 1'b1;
          if (flush_pend_d) begin
            state_d = ctrl_flush;
          end else begin
            // back to back hits
            fetch_req_ready_o = 1'b1;
            state_d           = ctrl_idle;
            if (fetch_req_valid_i) begin
              capture_o = 1'b1;
              rd_en_o   = 1'b1;
              state_d   = ctrl_compare;
            end
          end
        end else begin
          // refill request stays up until taken
          refill_req_valid_o = 1'b1;
          if (refill_req_ready_i) begin
            miss_o  = 1'b1;
            state_d = ctrl_miss;
          end
        end
      end
      // line arrives once, write it and answer from it
      ctrl_miss: begin
        if (refill_rsp_valid_i) begin
          wr_en_o           = 1'b1;
          advance_o         = &full_i;
          fetch_rsp_valid_o = 1'b1;
          fetch_rsp_o.data  = refill_rsp_i.data[word_off_i * word_bits +: word_bits];
          state_d           = flush_pend_d ? ctrl_flush : ctrl_idle;
        end
      end
      default: begin
        state_d = ctrl_flush;
      end
    endcase
  end

  // reset starts with the flush walk
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ctrl_flush;
      flush_cnt_q  <= '0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_cnt_q  <= flush_cnt_d;
      flush_pend_q <= flush_pend_d;
    end
  end

endmodule

/* logic/icache_top.sv */
`timescale 1ns/1ns

module icache_top #(
  parameter int unsigned num_ways = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // fetch side
  input  logic                    fetch_req_valid_i,
  output logic                    fetch_req_ready_o,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output logic                    fetch_rsp_valid_o,
  output icache_pkg::fetch_rsp_t  fetch_rsp_o,
  // memory side
  output logic                    refill_req_valid_o,
  input  logic                    refill_req_ready_i,
  output icache_pkg::refill_req_t refill_req_o,
  input  logic                    refill_rsp_valid_i,
  input  icache_pkg::refill_rsp_t refill_rsp_i,
  // performance counter
  output logic                    miss_o
);

  logic                            capture;
  icache_pkg::set_idx_t            index;
  icache_pkg::tag_t                tag;
  icache_pkg::word_off_t           word_off;
  logic                            rd_en;
  logic                            wr_en;
  logic                            flush_en;
  icache_pkg::set_idx_t            flush_idx;
  icache_pkg::tag_t  [num_ways-1:0] tags;
  logic              [num_ways-1:0] valids;
  icache_pkg::line_t [num_ways-1:0] lines;
  logic                            hit;
  icache_pkg::word_t               hit_word;
  logic                            latch;
  logic                            advance;
  logic              [num_ways-1:0] victim;

  ////////////////////////////////
  // request stage
  ////////////////////////////////

  icache_lookup i_lookup (
    .clk_i       ( clk_i                  ),
    .rst_ni      ( rst_ni                 ),
    .fetch_req_i ( fetch_req_i            ),
    .capture_i   ( capture                ),
    .index_o     ( index                  ),
    .tag_o       ( tag                    ),
    .word_off_o  ( word_off               ),
    .line_addr_o ( refill_req_o.line_addr )
  );

  icache_arrays #(
    .num_ways ( num_ways )
  ) i_arrays (
    .clk_i       ( clk_i             ),
    .rst_ni      ( rst_ni            ),
    .rd_en_i     ( rd_en             ),
    .wr_en_i     ( wr_en             ),
    .flush_en_i  ( flush_en          ),
    .flush_idx_i ( flush_idx         ),
    .index_i     ( index             ),
    .tag_i       ( tag               ),
    .wr_way_i    ( victim            ),
    .line_i      ( refill_rsp_i.data ),
    .tags_o      ( tags              ),
    .valids_o    ( valids            ),
    .lines_o     ( lines             )
  );

  ////////////////////////////////
  // compare stage
  ////////////////////////////////

  icache_hit_check #(
    .num_ways ( num_ways )
  ) i_hit_check (
    .tags_i     ( tags     ),
    .valids_i   ( valids   ),
    .lines_i    ( lines    ),
    .tag_i      ( tag      ),
    .word_off_i ( word_off ),
    .hit_o      ( hit      ),
    .word_o     ( hit_word )
  );

  icache_replace #(
    .num_ways ( num_ways )
  ) i_replace (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .valids_i  ( valids  ),
    .latch_i   ( latch   ),
    .advance_i ( advance ),
    .victim_o  ( victim  )
  );

  icache_ctrl #(
    .num_ways ( num_ways )
  ) i_ctrl (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .flush_i            ( flush_i            ),
    .fetch_req_valid_i  ( fetch_req_valid_i  ),
    .fetch_req_ready_o  ( fetch_req_ready_o  ),
    .capture_o          ( capture            ),
    .hit_i              ( hit                ),
    .hit_word_i         ( hit_word           ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_i       ( refill_rsp_i       ),
    .word_off_i         ( word_off           ),
    .fetch_rsp_valid_o  ( fetch_rsp_valid_o  ),
    .fetch_rsp_o        ( fetch_rsp_o        ),
    .rd_en_o            ( rd_en              ),
    .wr_en_o            ( wr_en              ),
    .flush_en_o         ( flush_en           ),
    .flush_idx_o        ( flush_idx          ),
    .latch_o            ( latch              ),
    .advance_o          ( advance            ),
    .full_i             ( valids             ),
    .miss_o             ( miss_o             )
  );

endmodule

/* testbench/tb_icache.sv */
`timescale 1ns/1ns

module tb_icache;

  localparam int unsigned num_ways = 4;
  localparam int unsigned num_sets = icache_pkg::num_sets;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    flush_i;
  logic                    fetch_req_valid_i;
  logic                    fetch_req_ready_o;
  icache_pkg::fetch_req_t  fetch_req_i;
  logic                    fetch_rsp_valid_o;
  icache_pkg::fetch_rsp_t  fetch_rsp_o;
  logic                    refill_req_valid_o;
  logic                    refill_req_ready_i;
  icache_pkg::refill_req_t refill_req_o;
  logic                    refill_rsp_valid_i;
  icache_pkg::refill_rsp_t refill_rsp_i;
  logic                    miss_o;

  int seed = 37;
  int cycle = 0;
  // outstanding requests with the oldest at the front
  icache_pkg::addr_t exp_q[$];
  int                acc_q[$];
  int                last_lat = 0;
  int                refill_cnt = 0;
  int                miss_cnt = 0;
  icache_pkg::addr_t last_line = '0;
  int                errors = 0;
  int                chk_errors = 0;
  int                num_tests = 0;
  int                tests_failed = 0;
  bit                hung = 1'b0;

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  // word at a byte address is a hash of its word address
  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t addr);
    logic [31:0] h;
    h = {addr[31:2], 2'b00} ^ 32'h9e37_79b9;
    h = h ^ (h >> 13);
    h = h * 32'h5bd1_e995;
    return h ^ (h >> 15);
  endfunction

  // word 0 sits in the low bits of the line
  function automatic icache_pkg::line_t mem_line(input icache_pkg::addr_t line_addr);
    icache_pkg::line_t l;
    for (int k = 0; k < 4; k++) begin
      l[32*k +: 32] = mem_word(line_addr | icache_pkg::addr_t'(4 * k));
    end
    return l;
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  icache_top #(
    .num_ways ( num_ways )
  ) dut_i (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .flush_i            ( flush_i            ),
    .fetch_req_valid_i  ( fetch_req_valid_i  ),
    .fetch_req_ready_o  ( fetch_req_ready_o  ),
    .fetch_req_i        ( fetch_req_i        ),
    .fetch_rsp_valid_o  ( fetch_rsp_valid_o  ),
    .fetch_rsp_o        ( fetch_rsp_o        ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_req_o       ( refill_req_o       ),
    .refill_rsp_valid_i ( refill_rsp_valid_i ),
    .refill_rsp_i       ( refill_rsp_i       ),
    .miss_o             ( miss_o             )
  );

  ////////////////////////////////
  // memory model
  ////////////////////////////////

  // ready is random and the line comes back 1 to 5 cycles after the transfer
  initial begin : memory_model
    int                rsp_wait;
    bit                rdy;
    icache_pkg::addr_t pend;
    rsp_wait           = 0;
    pend               = '0;
    refill_req_ready_i = 1'b0;
    refill_rsp_valid_i = 1'b0;
    refill_rsp_i       = '0;
    forever begin
      @(posedge clk_i);
      #2;
      refill_rsp_valid_i = 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          refill_rsp_valid_i = 1'b1;
          refill_rsp_i.data  = mem_line(pend);
        end
      end
      rdy = ($random(seed) & 1) != 0;
      // one refill at a time
      refill_req_ready_i = rdy && (rsp_wait == 0);
      @(negedge clk_i);
      if (refill_req_valid_o && refill_req_ready_i) begin
        pend      = refill_req_o.line_addr;
        last_line = pend;
        refill_cnt++;
        rsp_wait  = 1 + ({$random(seed)} % 5);
      end
    end
  end

  // responses are checked mid cycle in request order
  initial begin : check_rsp
    icache_pkg::addr_t a;
    int                c;
    forever begin
      @(negedge clk_i);
      if (miss_o) begin
        miss_cnt++;
      end
      if (fetch_rsp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("fetch response arrived with no request outstanding");
          chk_errors++;
        end else begin
          a        = exp_q.pop_front();
          c        = acc_q.pop_front();
          last_lat = cycle - c;
          if (fetch_rsp_o.data !== mem_word(a)) begin
            $display("[ERROR] fetch_rsp_o.data addr %h got %h expected %h",
                     a, fetch_rsp_o.data, mem_word(a));
            chk_errors++;
          end
        end
      end
    end
  end

  ////////////////////////////////
  // stimulus helpers
  ////////////////////////////////

  // hold valid and address until the cache takes them
  task automatic issue_fetch(input icache_pkg::addr_t addr);
    int waited;
    waited = 0;
    if (hung) begin
      return;
    end
    fetch_req_valid_i = 1'b1;
    fetch_req_i.addr  = addr;
    forever begin
      @(negedge clk_i);
      if (fetch_req_ready_o) begin
        exp_q.push_back(addr);
        acc_q.push_back(cycle);
        break;
      end
      waited++;
      if (waited > 400) begin
        $display("request to %h was not accepted within 400 cycles", addr);
        hung = 1'b1;
        errors++;
        break;
      end
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #2;
    fetch_req_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && !hung) begin
      @(negedge clk_i);
      waited++;
      if (waited > 200) begin
        $display("responses still missing after 200 cycles");
        hung = 1'b1;
        errors++;
      end
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    num_tests++;
    if (errors + chk_errors != err_before) begin
      tests_failed++;
      $display("test %0d %s: FAILED", num_tests, name);
    end else begin
      $display("test %0d %s: ok", num_tests, name);
    end
  endtask

  ////////////////////////////////
  // test sequence
  ////////////////////////////////

  initial begin : stimulus
    int                e0;
    int                r0;
    int                m0;
    int                ready_at;
    icache_pkg::addr_t a;
    // reset goes low after 1 ns
    rst_ni            = 1'b1;
    flush_i           = 1'b0;
    fetch_req_valid_i = 1'b0;
    fetch_req_i       = '0;
    #1;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // the first request waits through the flush walk and nothing leaves the cache
    e0                = errors + chk_errors;
    a                 = 32'h0000_1234;
    ready_at          = -1;
    fetch_req_valid_i = 1'b1;
    fetch_req_i.addr  = a;
    for (int i = 0; i < num_sets + 16 && ready_at < 0; i++) begin
      @(negedge clk_i);
      if (refill_req_valid_o || fetch_rsp_valid_o || miss_o) begin
        $display("cache output active during the reset flush walk");
        errors++;
      end
      if (fetch_req_ready_o) begin
        ready_at = i;
        exp_q.push_back(a);
        acc_q.push_back(cycle);
      end
    end
    if (ready_at < 0) begin
      $display("fetch_req_ready_o did not rise after the reset flush walk");
      errors++;
    end else if (ready_at < int'(num_sets)) begin
      $display("fetch_req_ready_o rose %0d cycles after reset, before the walk ended",
               ready_at);
      errors++;
    end
    @(posedge clk_i);
    #2;
    fetch_req_valid_i = 1'b0;
    report_test("reset flush", e0);

    // cold miss makes one line aligned refill
    e0 = errors + chk_errors;
    r0 = refill_cnt;
    m0 = miss_cnt;
    wait_responses();
    if (refill_cnt - r0 != 1) begin
      $display("first fetch to a line made %0d refills instead of 1", refill_cnt - r0);
      errors++;
    end
    if (miss_cnt - m0 != 1) begin
      $display("first fetch to a line gave %0d miss pulses instead of 1", miss_cnt - m0);
      errors++;
    end
    if (last_line !== {a[31:4], 4'h0}) begin
      $display("[ERROR] refill_req_o.line_addr got %h expected %h", last_line, {a[31:4], 4'h0});
      errors++;
    end
    report_test("cold miss", e0);

    // other word of the same line hits in one cycle
    e0 = errors + chk_errors;
    r0 = refill_cnt;
    issue_fetch(32'h0000_1238);
    wait_responses();
    if (refill_cnt != r0) begin
      $display("fetch to a cached line started a refill");
      errors++;
    end
    if (last_lat != 1) begin
      $display("hit answered %0d cycles after acceptance instead of 1", last_lat);
      errors++;
    end
    report_test("hit latency", e0);

    // fill every way of set 5 and refetch them before one tag too many
    e0 = errors + chk_errors;
    r0 = refill_cnt;
    for (int pass = 0; pass < 2; pass++) begin
      for (int t = 1; t <= num_ways; t++) begin
        issue_fetch({22'(t), 6'd5, 2'(pass), 2'b00});
      end
    end
    wait_responses();
    if (refill_cnt - r0 != num_ways) begin
      $display("filling one set made %0d refills instead of %0d", refill_cnt - r0, num_ways);
      errors++;
    end
    r0 = refill_cnt;
    issue_fetch({22'(num_ways + 1), 6'd5, 4'h8});
    wait_responses();
    if (refill_cnt - r0 != 1) begin
      $display("extra tag in a full set made %0d refills instead of 1", refill_cnt - r0);
      errors++;
    end
    report_test("set fill", e0);

    // flushed line must be fetched again
    e0 = errors + chk_errors;
    pulse_flush();
    r0 = refill_cnt;
    issue_fetch(32'h0000_1234);
    wait_responses();
    if (refill_cnt - r0 != 1) begin
      $display("fetch after flush made %0d refills instead of 1", refill_cnt - r0);
      errors++;
    end
    report_test("flush", e0);

    // random stream over 16 tags with back to back requests
    e0 = errors + chk_errors;
    r0 = refill_cnt;
    m0 = miss_cnt;
    for (int n = 0; n < 200; n++) begin
      a = {$random(seed)} & 32'h0000_3ffc;
      issue_fetch(a);
    end
    wait_responses();
    if (miss_cnt - m0 != refill_cnt - r0) begin
      $display("miss pulses %0d do not match refill transfers %0d",
               miss_cnt - m0, refill_cnt - r0);
      errors++;
    end
    report_test("random stream", e0);

    $display("tests %0d, failed %0d, errors %0d", num_tests, tests_failed, errors + chk_errors);
    if (errors + chk_errors == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/icache_pkg.sv
logic/icache_lookup.sv
logic/icache_arrays.sv
logic/icache_replace.sv
logic/icache_hit_check.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_icache -f compile.f -o tb_icache_sim \
  && ./obj_dir/tb_icache_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
